//--- bench/edge_rqst_gen_tb.sv
`timescale 1ns/1ps

module edge_rqst_gen_tb
    import edge_rqst_pkg::*;
();

    localparam string STIM_FILE = "bench/edge_rqst_stim.txt";

    logic                              clk;
    logic                              rst;
    logic [CORE_NUM-1:0]               in_valid;
    logic [CORE_NUM*ADDR_WIDTH-1:0]    in_addr;
    logic [CORE_NUM*CORE_NUM-1:0]      in_mask;
    logic [CORE_NUM-1:0]               in_push_flag;
    logic [CORE_NUM*V_ID_WIDTH-1:0]    in_v_id;
    logic [CORE_NUM*V_VALUE_WIDTH-1:0] in_v_value;
    logic [CORE_NUM-1:0]               iteration_end_in;
    logic [CORE_NUM-1:0]               iteration_end_in_valid;
    logic                              hbm_full;
    logic                              next_stage_full;
    logic [CORE_NUM-1:0]               stage_full;
    logic [ADDR_WIDTH-1:0]             rd_edge_addr;
    logic                              rd_edge_valid;
    logic [CORE_NUM-1:0]               push_flag;
    logic [CORE_NUM*V_ID_WIDTH-1:0]    active_v_id;
    logic [CORE_NUM*V_VALUE_WIDTH-1:0] active_v_value;
    logic [CORE_NUM-1:0]               active_v_id_valid;
    logic                              iteration_end;

    int     err_value = 0;
    int     err_other = 0;
    int     cycles = 0;
    int     cycle_limit = 0;
    integer seed = 74725;
    int     occ [CORE_NUM];
    logic   stall_prev;

    // expected reads in issue order
    logic [ADDR_WIDTH-1:0]             exp_addr_q [$];
    logic [CORE_NUM-1:0]               exp_push_q [$];
    logic [CORE_NUM*V_ID_WIDTH-1:0]    exp_id_q [$];
    logic [CORE_NUM*V_VALUE_WIDTH-1:0] exp_value_q [$];

    edge_rqst_gen #(
        .CORE_NUM    (CORE_NUM),
        .ADDR_WIDTH  (ADDR_WIDTH),
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .QUEUE_PFULL (QUEUE_PFULL)
    ) UUT (
        .clk                    (clk),
        .rst                    (rst),
        .in_valid               (in_valid),
        .in_addr                (in_addr),
        .in_mask                (in_mask),
        .in_push_flag           (in_push_flag),
        .in_v_id                (in_v_id),
        .in_v_value             (in_v_value),
        .iteration_end_in       (iteration_end_in),
        .iteration_end_in_valid (iteration_end_in_valid),
        .hbm_full               (hbm_full),
        .next_stage_full        (next_stage_full),
        .stage_full             (stage_full),
        .rd_edge_addr           (rd_edge_addr),
        .rd_edge_valid          (rd_edge_valid),
        .push_flag              (push_flag),
        .active_v_id            (active_v_id),
        .active_v_value         (active_v_value),
        .active_v_id_valid      (active_v_id_valid),
        .iteration_end          (iteration_end)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit scales with the stimulus length
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles with stimulus left", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic int count_lines(input int f);
        int c;
        int n;
        n = 0;
        c = $fgetc(f);
        while (c != -1) begin
            if (c == 10) begin
                n++;
            end
            c = $fgetc(f);
        end
        return n;
    endfunction

    task automatic check_issue();
        logic [ADDR_WIDTH-1:0]             a;
        logic [CORE_NUM-1:0]               p;
        logic [CORE_NUM*V_ID_WIDTH-1:0]    id;
        logic [CORE_NUM*V_VALUE_WIDTH-1:0] v;
        a = exp_addr_q.pop_front();
        p = exp_push_q.pop_front();
        id = exp_id_q.pop_front();
        v = exp_value_q.pop_front();
        assert (rd_edge_addr === a) else begin
            $display("ERROR %0t: rd_edge_addr %h, expected %h", $time, rd_edge_addr, a);
            err_value++;
        end
        assert (push_flag === p && active_v_id_valid === '1) else begin
            $display("ERROR %0t: push_flag %b valid %b at %h, expected %b valid all",
                     $time, push_flag, active_v_id_valid, a, p);
            err_value++;
        end
        assert (active_v_id === id && active_v_value === v) else begin
            $display("ERROR %0t: lanes id %h value %h at %h, expected id %h value %h",
                     $time, active_v_id, active_v_value, a, id, v);
            err_value++;
        end
    endtask

    // registered outputs compared half a cycle after each rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (stall_prev) begin
                assert (rd_edge_valid === 1'b0 && active_v_id_valid === '0) else begin
                    $display("ERROR %0t: output valid after a stalled cycle", $time);
                    err_value++;
                end
                assert (rd_edge_addr === '0 && push_flag === '0 &&
                        active_v_id === '0 && active_v_value === '0) else begin
                    $display("ERROR %0t: output data not zero after a stalled cycle", $time);
                    err_value++;
                end
            end
            if (rd_edge_valid === 1'b1) begin
                assert (exp_addr_q.size() != 0) else begin
                    $display("read of address %h issued with no request left to expect",
                             rd_edge_addr);
                    err_other++;
                end
                if (exp_addr_q.size() != 0) begin
                    check_issue();
                end
            end
        end
        stall_prev = hbm_full || next_stage_full;
    end

    task automatic write_req(input int core, input logic [ADDR_WIDTH-1:0] addr,
                             input logic [CORE_NUM-1:0] mask, input logic push,
                             input logic [V_ID_WIDTH-1:0] id,
                             input logic [V_VALUE_WIDTH-1:0] value);
        logic [CORE_NUM-1:0] exp_full;
        @(posedge clk);
        #1;
        in_addr[core*ADDR_WIDTH +: ADDR_WIDTH] = addr;
        in_mask[core*CORE_NUM +: CORE_NUM] = mask;
        in_push_flag[core] = push;
        in_v_id[core*V_ID_WIDTH +: V_ID_WIDTH] = id;
        in_v_value[core*V_VALUE_WIDTH +: V_VALUE_WIDTH] = value;
        in_valid[core] = 1'b1;
        @(posedge clk);
        #1;
        in_valid = '0;
        occ[core]++;
        @(negedge clk);
        // queues are stalled while loading, so occupancy is the write count
        for (int c = 0; c < CORE_NUM; c++) begin
            exp_full[c] = (occ[c] >= QUEUE_PFULL);
        end
        assert (stage_full === exp_full) else begin
            $display("ERROR %0t: stage_full %b, expected %b", $time, stage_full, exp_full);
            err_value++;
        end
    endtask

    task automatic read_expect(input int fd);
        int                                code;
        int                                p;
        logic [ADDR_WIDTH-1:0]             a;
        logic [V_ID_WIDTH-1:0]             id;
        logic [V_VALUE_WIDTH-1:0]          v;
        logic [CORE_NUM-1:0]               e_push;
        logic [CORE_NUM*V_ID_WIDTH-1:0]    e_id;
        logic [CORE_NUM*V_VALUE_WIDTH-1:0] e_value;
        code = $fscanf(fd, "%h", a);
        for (int l = 0; l < CORE_NUM; l++) begin
            code = code + $fscanf(fd, "%d %h %h", p, id, v);
            e_push[l] = p[0];
            e_id[l*V_ID_WIDTH +: V_ID_WIDTH] = id;
            e_value[l*V_VALUE_WIDTH +: V_VALUE_WIDTH] = v;
        end
        assert (code == 1 + 3 * CORE_NUM) else begin
            $display("stimulus file has an incomplete E line");
            err_other++;
        end
        exp_addr_q.push_back(a);
        exp_push_q.push_back(e_push);
        exp_id_q.push_back(e_id);
        exp_value_q.push_back(e_value);
    endtask

    // release with random memory stalls until every expected read is seen
    task automatic drain_queues();
        while (exp_addr_q.size() != 0) begin
            @(posedge clk);
            #1;
            hbm_full = (($random(seed) & 3) == 0);
        end
        @(posedge clk);
        #1;
        hbm_full = 1'b0;
        repeat (3) @(negedge clk);
        assert (stage_full === '0) else begin
            $display("ERROR %0t: stage_full %b after drain, expected all low", $time, stage_full);
            err_value++;
        end
        for (int c = 0; c < CORE_NUM; c++) begin
            occ[c] = 0;
        end
    endtask

    task automatic check_iter_end(input logic [CORE_NUM-1:0] done_in,
                                  input logic [CORE_NUM-1:0] done_valid, input logic exp);
        @(posedge clk);
        #1;
        iteration_end_in = done_in;
        iteration_end_in_valid = done_valid;
        @(posedge clk);
        #1;
        iteration_end_in = '0;
        iteration_end_in_valid = '0;
        @(negedge clk);
        assert (iteration_end === exp) else begin
            $display("ERROR %0t: iteration_end %b, expected %b", $time, iteration_end, exp);
            err_value++;
        end
        @(negedge clk);
        assert (iteration_end === 1'b0) else begin
            $display("ERROR %0t: iteration_end held longer than one cycle", $time);
            err_value++;
        end
    endtask

    task automatic run_stimulus(input int fd);
        int                       ch;
        int                       code;
        int                       core;
        int                       push;
        int                       nsf;
        int                       hbm;
        int                       exp_end;
        logic [ADDR_WIDTH-1:0]    addr;
        logic [CORE_NUM-1:0]      mask;
        logic [CORE_NUM-1:0]      done_in;
        logic [CORE_NUM-1:0]      done_valid;
        logic [V_ID_WIDTH-1:0]    id;
        logic [V_VALUE_WIDTH-1:0] value;
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == int'("#")) begin
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (ch == int'("W")) begin
                code = $fscanf(fd, "%d %h %h %d %h %h", core, addr, mask, push, id, value);
                assert (code == 6) else begin
                    $display("stimulus file has an incomplete W line");
                    err_other++;
                end
                if (code == 6) begin
                    write_req(core, addr, mask, push[0], id, value);
                end
            end else if (ch == int'("S")) begin
                code = $fscanf(fd, "%d %d", nsf, hbm);
                assert (code == 2) else begin
                    $display("stimulus file has an incomplete S line");
                    err_other++;
                end
                if (code == 2) begin
                    @(posedge clk);
                    #1;
                    next_stage_full = nsf[0];
                    hbm_full = hbm[0];
                    if (nsf == 0 && hbm == 0) begin
                        drain_queues();
                    end
                end
            end else if (ch == int'("E")) begin
                read_expect(fd);
            end else if (ch == int'("X")) begin
                code = $fscanf(fd, "%h %h %d", done_in, done_valid, exp_end);
                assert (code == 3) else begin
                    $display("stimulus file has an incomplete X line");
                    err_other++;
                end
                if (code == 3) begin
                    check_iter_end(done_in, done_valid, exp_end[0]);
                end
            end else if (ch > 32) begin
                $display("stimulus file has an unknown tag character %0d", ch);
                err_other++;
            end
            ch = $fgetc(fd);
        end
    endtask

    initial begin
        int fd;
        rst = 1'b1;
        in_valid = '0;
        in_addr = '0;
        in_mask = '0;
        in_push_flag = '0;
        in_v_id = '0;
        in_v_value = '0;
        iteration_end_in = '0;
        iteration_end_in_valid = '0;
        hbm_full = 1'b0;
        next_stage_full = 1'b0;
        stall_prev = 1'b0;
        for (int c = 0; c < CORE_NUM; c++) begin
            occ[c] = 0;
        end
        fd = $fopen(STIM_FILE, "r");
        assert (fd != 0) else begin
            $display("could not open the stimulus file %s", STIM_FILE);
            err_other++;
        end
        if (fd != 0) begin
            cycle_limit = 4 * count_lines(fd) + 100;
            $fclose(fd);
            fd = $fopen(STIM_FILE, "r");
            repeat (2) @(posedge clk);
            #1;
            rst = 1'b0;
            @(negedge clk);
            assert (rd_edge_valid === 1'b0 && active_v_id_valid === '0 &&
                    push_flag === '0 && iteration_end === 1'b0 &&
                    stage_full === '0) else begin
                $display("ERROR %0t: outputs not idle after reset", $time);
                err_value++;
            end
            run_stimulus(fd);
            $fclose(fd);
        end
        repeat (2) @(negedge clk);
        assert (exp_addr_q.size() == 0) else begin
            $display("%0d expected reads were never issued", exp_addr_q.size());
            err_other++;
        end
        $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- bench/edge_rqst_stim.txt
# W core addr mask push id value | S next_stage_full hbm_full (both 0 drains the queues)
# E addr, then push id value for each lane 0..3 | X done done_valid expected_end
S 1 0
W 0 0010 1 1 0a00 0100
W 0 0030 2 0 0a01 0101
W 1 0020 4 1 0b00 0200
W 1 0030 3 1 0b01 0201
W 2 0005 8 1 0c00 0300
W 3 0030 4 0 0d00 0400
W 3 0040 f 1 0d01 0401
E 0005 1 ffff 0001 1 ffff 0001 1 ffff 0001 1 0c00 0300
E 0010 1 0a00 0100 1 ffff 0001 1 ffff 0001 1 ffff 0001
E 0020 1 ffff 0001 1 ffff 0001 1 0b00 0200 1 ffff 0001
E 0030 1 0b01 0201 0 0a01 0101 0 0d00 0400 1 ffff 0001
E 0040 1 0d01 0401 1 0d01 0401 1 0d01 0401 1 0d01 0401
X f f 0
X f 7 0
S 0 0
X f f 1
X e f 0
# one queue filled to the programmable-full level
S 0 1
W 1 0100 2 1 0e00 0500
W 1 0101 2 0 0e01 0501
W 1 0102 2 1 0e02 0502
W 1 0103 2 0 0e03 0503
W 1 0104 2 1 0e04 0504
W 1 0105 2 0 0e05 0505
E 0100 1 ffff 0001 1 0e00 0500 1 ffff 0001 1 ffff 0001
E 0101 1 ffff 0001 0 0e01 0501 1 ffff 0001 1 ffff 0001
E 0102 1 ffff 0001 1 0e02 0502 1 ffff 0001 1 ffff 0001
E 0103 1 ffff 0001 0 0e03 0503 1 ffff 0001 1 ffff 0001
E 0104 1 ffff 0001 1 0e04 0504 1 ffff 0001 1 ffff 0001
E 0105 1 ffff 0001 0 0e05 0505 1 ffff 0001 1 ffff 0001
S 0 0
X f f 1

//--- logic/edge_head_if.sv
`timescale 1ns/1ps

// head of one core queue as seen by the merge stage
interface edge_head_if
    import edge_rqst_pkg::*;
#(
    parameter int CORE_NUM   = edge_rqst_pkg::CORE_NUM,
    parameter int ADDR_WIDTH = edge_rqst_pkg::ADDR_WIDTH
);

    // head record, valid while empty is low
    logic [ADDR_WIDTH-1:0]    addr;
    logic [CORE_NUM-1:0]      mask;
    logic                     push_flag;
    logic [V_ID_WIDTH-1:0]    v_id;
    logic [V_VALUE_WIDTH-1:0] v_value;
    logic                     empty;

    // removes the head at the next edge
    logic                     pop;

    modport queue_side (
        output addr, mask, push_flag, v_id, v_value, empty,
        input  pop
    );

    modport merge_side (
        input  addr, mask, push_flag, v_id, v_value, empty,
        output pop
    );

endinterface

//--- logic/edge_merge.sv
`timescale 1ns/1ps

// smallest-address merge over all queue heads
module edge_merge
    import edge_rqst_pkg::*;
#(
    parameter int CORE_NUM   = edge_rqst_pkg::CORE_NUM,
    parameter int ADDR_WIDTH = edge_rqst_pkg::ADDR_WIDTH
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              hbm_full,
    input  logic                              next_stage_full,
    input  logic [CORE_NUM-1:0]               iteration_end_in,
    input  logic [CORE_NUM-1:0]               iteration_end_in_valid,
    edge_head_if.merge_side                   heads [CORE_NUM],
    output logic [ADDR_WIDTH-1:0]             rd_edge_addr,
    output logic                              rd_edge_valid,
    output logic [CORE_NUM-1:0]               push_flag,
    output logic [CORE_NUM*V_ID_WIDTH-1:0]    active_v_id,
    output logic [CORE_NUM*V_VALUE_WIDTH-1:0] active_v_value,
    output logic [CORE_NUM-1:0]               active_v_id_valid,
    output logic                              iteration_end
);

    logic [CORE_NUM-1:0]      head_empty;
    logic [CORE_NUM-1:0]      head_push;
    logic [ADDR_WIDTH-1:0]    head_key [CORE_NUM];
    logic [CORE_NUM-1:0]      head_mask [CORE_NUM];
    logic [V_ID_WIDTH-1:0]    head_v_id [CORE_NUM];
    logic [V_VALUE_WIDTH-1:0] head_v_value [CORE_NUM];

    logic [CORE_NUM-1:0]      winner;
    logic                     all_empty;
    logic                     issue;
    logic [ADDR_WIDTH-1:0]    issue_addr;

    logic [CORE_NUM-1:0]      lane_push;
    logic [V_ID_WIDTH-1:0]    lane_v_id [CORE_NUM];
    logic [V_VALUE_WIDTH-1:0] lane_v_value [CORE_NUM];

    // unpack the heads, empty ones compare as the largest address
    for (genvar c = 0; c < CORE_NUM; c++) begin : g_head
        assign head_empty[c]   = heads[c].empty;
        assign head_key[c]     = heads[c].empty ? '1 : heads[c].addr;
        assign head_mask[c]    = heads[c].mask;
        assign head_push[c]    = heads[c].push_flag;
        assign head_v_id[c]    = heads[c].v_id;
        assign head_v_value[c] = heads[c].v_value;
        // every head holding the smallest address leaves together
        assign heads[c].pop    = issue && winner[c];
    end

    assign all_empty = &head_empty;
    assign issue     = !hbm_full && !next_stage_full && !all_empty;

    // a non-empty head wins when no other key is smaller
    always_comb begin
        for (int c = 0; c < CORE_NUM; c++) begin
            winner[c] = !head_empty[c];
            for (int k = 0; k < CORE_NUM; k++) begin
                if (head_key[k] < head_key[c]) begin
                    winner[c] = 1'b0;
                end
            end
        end
    end

    // all winners share one address, take the lowest index
    always_comb begin
        issue_addr = '0;
        for (int c = CORE_NUM - 1; c >= 0; c--) begin
            if (winner[c]) begin
                issue_addr = head_key[c];
            end
        end
    end

    // per lane, lowest-index winner with its mask bit set
    always_comb begin
        for (int l = 0; l < CORE_NUM; l++) begin
            lane_push[l]    = 1'b1;
            lane_v_id[l]    = FILLER_V_ID;
            lane_v_value[l] = FILLER_V_VALUE;
            for (int c = CORE_NUM - 1; c >= 0; c--) begin
                if (winner[c] && head_mask[c][l]) begin
                    lane_push[l]    = head_push[c];
                    lane_v_id[l]    = head_v_id[c];
                    lane_v_value[l] = head_v_value[c];
                end
            end
        end
    end

    // output register, all zero on a stalled or idle cycle
    always_ff @(posedge clk) begin
        if (rst || !issue) begin
            rd_edge_addr      <= '0;
            rd_edge_valid     <= 1'b0;
            push_flag         <= '0;
            active_v_id       <= '0;
            active_v_value    <= '0;
            active_v_id_valid <= '0;
        end else begin
            rd_edge_addr      <= issue_addr;
            rd_edge_valid     <= 1'b1;
            push_flag         <= lane_push;
            active_v_id_valid <= '1;
            for (int l = 0; l < CORE_NUM; l++) begin
                active_v_id[l*V_ID_WIDTH +: V_ID_WIDTH]          <= lane_v_id[l];
                active_v_value[l*V_VALUE_WIDTH +: V_VALUE_WIDTH] <= lane_v_value[l];
            end
        end
    end

    // end of iteration once every core reports done and nothing is queued
    always_ff @(posedge clk) begin
        if (rst) begin
            iteration_end <= 1'b0;
        end else begin
            iteration_end <= (&iteration_end_in) && (&iteration_end_in_valid) && all_empty;
        end
    end

endmodule

//--- logic/edge_req_queue.sv
`timescale 1ns/1ps

// first-word-fall-through queue for one core
module edge_req_queue
    import edge_rqst_pkg::*;
#(
    parameter int QUEUE_DEPTH = edge_rqst_pkg::QUEUE_DEPTH,
    parameter int QUEUE_PFULL = edge_rqst_pkg::QUEUE_PFULL
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_en,
    input  logic [ADDR_WIDTH-1:0]    wr_addr,
    input  logic [CORE_NUM-1:0]      wr_mask,
    input  logic                     wr_push_flag,
    input  logic [V_ID_WIDTH-1:0]    wr_v_id,
    input  logic [V_VALUE_WIDTH-1:0] wr_v_value,
    output logic                     stage_full,
    edge_head_if.queue_side          head
);

    localparam int REC_WIDTH = ADDR_WIDTH + CORE_NUM + 1 + V_ID_WIDTH + V_VALUE_WIDTH;
    localparam int PTR_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

    // whole request record per entry
    logic [REC_WIDTH-1:0] mem [QUEUE_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic [CNT_WIDTH-1:0] count_next;
    logic                 wr_ok;
    logic                 rd_ok;

    // wrap at depth, which need not be a power of two
    function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // writes into a full buffer are dropped
    assign wr_ok = wr_en && (count != QUEUE_DEPTH);
    assign rd_ok = head.pop && (count != '0);

    always_comb begin
        count_next = count;
        if (wr_ok && !rd_ok) begin
            count_next = count + 1'b1;
        end else if (rd_ok && !wr_ok) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= {wr_addr, wr_mask, wr_push_flag, wr_v_id, wr_v_value};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            stage_full <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_ok) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count_next;
            // tracks the occupancy after this edge
            stage_full <= (count_next >= QUEUE_PFULL);
        end
    end

    // oldest entry shown without read latency
    assign {head.addr, head.mask, head.push_flag, head.v_id, head.v_value} = mem[rd_ptr];
    assign head.empty = (count == '0);

endmodule

//--- logic/edge_rqst_gen.sv
`timescale 1ns/1ps

// edge request generator for one memory pseudo channel
module edge_rqst_gen
    import edge_rqst_pkg::*;
#(
    parameter int CORE_NUM    = edge_rqst_pkg::CORE_NUM,
    parameter int ADDR_WIDTH  = edge_rqst_pkg::ADDR_WIDTH,
    parameter int QUEUE_DEPTH = edge_rqst_pkg::QUEUE_DEPTH,
    parameter int QUEUE_PFULL = edge_rqst_pkg::QUEUE_PFULL
) (
    input  logic                              clk,
    input  logic                              rst,

    // requests from the cores, flattened in core order
    input  logic [CORE_NUM-1:0]               in_valid,
    input  logic [CORE_NUM*ADDR_WIDTH-1:0]    in_addr,
    input  logic [CORE_NUM*CORE_NUM-1:0]      in_mask,
    input  logic [CORE_NUM-1:0]               in_push_flag,
    input  logic [CORE_NUM*V_ID_WIDTH-1:0]    in_v_id,
    input  logic [CORE_NUM*V_VALUE_WIDTH-1:0] in_v_value,
    input  logic [CORE_NUM-1:0]               iteration_end_in,
    input  logic [CORE_NUM-1:0]               iteration_end_in_valid,

    // back-pressure from downstream
    input  logic                              hbm_full,
    input  logic                              next_stage_full,

    output logic [CORE_NUM-1:0]               stage_full,
    output logic [ADDR_WIDTH-1:0]             rd_edge_addr,
    output logic                              rd_edge_valid,
    output logic [CORE_NUM-1:0]               push_flag,
    output logic [CORE_NUM*V_ID_WIDTH-1:0]    active_v_id,
    output logic [CORE_NUM*V_VALUE_WIDTH-1:0] active_v_value,
    output logic [CORE_NUM-1:0]               active_v_id_valid,
    output logic                              iteration_end
);

    // one head bus per core
    edge_head_if #(
        .CORE_NUM   (CORE_NUM),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) head_bus [CORE_NUM] ();

    for (genvar i = 0; i < CORE_NUM; i++) begin : g_queue
        edge_req_queue #(
            .QUEUE_DEPTH (QUEUE_DEPTH),
            .QUEUE_PFULL (QUEUE_PFULL)
        ) u_queue (
            .clk          (clk),
            .rst          (rst),
            .wr_en        (in_valid[i]),
            .wr_addr      (in_addr[i*ADDR_WIDTH +: ADDR_WIDTH]),
            .wr_mask      (in_mask[i*CORE_NUM +: CORE_NUM]),
            .wr_push_flag (in_push_flag[i]),
            .wr_v_id      (in_v_id[i*V_ID_WIDTH +: V_ID_WIDTH]),
            .wr_v_value   (in_v_value[i*V_VALUE_WIDTH +: V_VALUE_WIDTH]),
            .stage_full   (stage_full[i]),
            .head         (head_bus[i])
        );
    end

    edge_merge #(
        .CORE_NUM   (CORE_NUM),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_merge (
        .clk                    (clk),
        .rst                    (rst),
        .hbm_full               (hbm_full),
        .next_stage_full        (next_stage_full),
        .iteration_end_in       (iteration_end_in),
        .iteration_end_in_valid (iteration_end_in_valid),
        .heads                  (head_bus),
        .rd_edge_addr           (rd_edge_addr),
        .rd_edge_valid          (rd_edge_valid),
        .push_flag              (push_flag),
        .active_v_id            (active_v_id),
        .active_v_value         (active_v_value),
        .active_v_id_valid      (active_v_id_valid),
        .iteration_end          (iteration_end)
    );

endmodule

//--- logic/edge_rqst_pkg.sv
package edge_rqst_pkg;

    // group size, also the number of output lanes
    parameter int CORE_NUM = 4;

    // request field widths
    parameter int ADDR_WIDTH = 16;
    parameter int V_ID_WIDTH = 16;
    parameter int V_VALUE_WIDTH = 16;

    // per-core queue sizing
    parameter int QUEUE_DEPTH = 8;
    // occupancy that raises stage_full toward the core
    parameter int QUEUE_PFULL = 6;

    // filler record for lanes that no winning head claims
    // the next stage recognizes the all-ones id and drops it
    parameter logic [V_ID_WIDTH-1:0] FILLER_V_ID = '1;
    parameter logic [V_VALUE_WIDTH-1:0] FILLER_V_VALUE = V_VALUE_WIDTH'(1);

endpackage

//--- run_sim.sh
#!/bin/sh
# build and run the edge request generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module edge_rqst_gen_tb -o edge_rqst_sim
./obj_dir/edge_rqst_sim | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- sim.f
logic/edge_rqst_pkg.sv
logic/edge_head_if.sv
logic/edge_req_queue.sv
logic/edge_merge.sv
logic/edge_rqst_gen.sv
bench/edge_rqst_gen_tb.sv
